// File: Bender.yml
package:
  name: edge_thin

sources:
  - src/edge_pkg.sv
  - src/pixel_fifo_if.sv
  - src/pixel_fifo.sv
  - src/non_maximum_suppressor.sv
  - src/edge_thin_top.sv
  - target: test
    files:
      - sim/tb_edge_thin.sv

// File: all.f
src/edge_pkg.sv
src/pixel_fifo_if.sv
src/pixel_fifo.sv
src/non_maximum_suppressor.sv
src/edge_thin_top.sv
sim/tb_edge_thin.sv

// File: sim/tb_edge_thin.sv
// Self-checking testbench for edge_thin_top, compiled with the sources listed in all.f
`timescale 1ns/10ps

module tb_edge_thin import edge_pkg::*; ();

    localparam int pixel_count    = image_width * image_height;
    localparam int frame_count    = 3;
    localparam int total_pixels   = frame_count * pixel_count;
    localparam int timeout_cycles = 20 * total_pixels;
    localparam int reset_cycles   = 8;

    // Small range so that ties between values and between sums are common
    localparam int max_value = 5;

    logic   clock;
    logic   reset;
    logic   in_wr_en;
    pixel_t in_din;
    logic   in_full;
    logic   out_rd_en;
    logic   out_empty;
    pixel_t out_dout;

    pixel_t stim [total_pixels];
    pixel_t expected_q [$];
    int     wr_idx = 0;
    int     rd_idx = 0;
    int     cycle_count = 0;
    int     error_count;
    int     check_count = 0;
    logic   saw_full = 1'b0;

    edge_thin_top u_edge_thin_top (
        .clock     (clock),
        .reset     (reset),
        .in_wr_en  (in_wr_en),
        .in_din    (in_din),
        .in_full   (in_full),
        .out_rd_en (out_rd_en),
        .out_empty (out_empty),
        .out_dout  (out_dout)
    );

    always #5 clock = ~clock;

    function automatic pixel_t frame_pixel(input int frame, input int r, input int c);
        return stim[frame * pixel_count + r * image_width + c];
    endfunction

    function automatic logic is_border(input int pos);
        int r;
        int c;
        r = pos / image_width;
        c = pos % image_width;
        return (r == 0) || (r == image_height - 1) || (c == 0) || (c == image_width - 1);
    endfunction

    // Reference model of the suppression rule for one frame
    task automatic compute_expected(input int frame);
        pixel_t    nw, n, ne;
        pixel_t    w, ctr, e;
        pixel_t    sw, s, se;
        pixel_t    first, second;
        grad_sum_t sum_ns, sum_ew, sum_nw, sum_ne;
        for (int r = 0; r < image_height; r++) begin
            for (int c = 0; c < image_width; c++) begin
                if (is_border(r * image_width + c)) begin
                    expected_q.push_back('0);
                end else begin
                    nw  = frame_pixel(frame, r - 1, c - 1);
                    n   = frame_pixel(frame, r - 1, c);
                    ne  = frame_pixel(frame, r - 1, c + 1);
                    w   = frame_pixel(frame, r, c - 1);
                    ctr = frame_pixel(frame, r, c);
                    e   = frame_pixel(frame, r, c + 1);
                    sw  = frame_pixel(frame, r + 1, c - 1);
                    s   = frame_pixel(frame, r + 1, c);
                    se  = frame_pixel(frame, r + 1, c + 1);
                    sum_ns = grad_sum_t'(n) + grad_sum_t'(s);
                    sum_ew = grad_sum_t'(w) + grad_sum_t'(e);
                    sum_nw = grad_sum_t'(nw) + grad_sum_t'(se);
                    sum_ne = grad_sum_t'(ne) + grad_sum_t'(sw);
                    // Strongest direction picks the neighbours across it
                    if (sum_ns >= sum_ew && sum_ns >= sum_nw && sum_ns >= sum_ne) begin
                        first  = w;
                        second = e;
                    end else if (sum_ew >= sum_nw && sum_ew >= sum_ne) begin
                        first  = n;
                        second = s;
                    end else if (sum_nw >= sum_ne) begin
                        first  = ne;
                        second = sw;
                    end else begin
                        first  = nw;
                        second = se;
                    end
                    expected_q.push_back((ctr > first && ctr >= second) ? ctr : pixel_t'(0));
                end
            end
        end
    endtask

    // Long read stalls let both FIFOs fill up
    function automatic logic reader_stalled();
        return (cycle_count % 1200) < 300;
    endfunction

    // Handshakes complete on the rising edge, outputs are checked there
    always @(posedge clock) begin : check_output
        pixel_t expected;
        cycle_count <= cycle_count + 1;
        if (in_full) begin
            saw_full <= 1'b1;
        end
        if (in_wr_en && !in_full) begin
            wr_idx <= wr_idx + 1;
        end
        if (out_rd_en && !out_empty) begin
            check_count <= check_count + 1;
            rd_idx      <= rd_idx + 1;
            assert (expected_q.size() > 0) else begin
                error_count++;
                $display("Output pixel read after all expected pixels were consumed");
            end
            if (expected_q.size() > 0) begin
                expected = expected_q.pop_front();
                assert (out_dout == expected) else begin
                    error_count++;
                    $display("[FAIL] out_dout expected %h got %h at pixel %0d",
                             expected, out_dout, rd_idx);
                end
                assert (!is_border(rd_idx % pixel_count) || out_dout == '0) else begin
                    error_count++;
                    $display("[FAIL] out_dout expected %h got %h at border pixel %0d",
                             8'h00, out_dout, rd_idx);
                end
            end
        end
    end

    always @(negedge clock) begin
        // Inputs stay idle until reset has been released
        if (cycle_count <= reset_cycles) begin
            in_wr_en  = 1'b0;
            out_rd_en = 1'b0;
        end else begin
            in_wr_en  = (wr_idx < total_pixels) && !in_full && ($urandom_range(0, 3) != 0);
            in_din    = (wr_idx < total_pixels) ? stim[wr_idx] : pixel_t'(0);
            out_rd_en = !out_empty && !reader_stalled() && ($urandom_range(0, 3) != 0);
        end
    end

    initial begin
        clock       = 1'b0;
        reset       = 1'b1;
        in_wr_en    = 1'b0;
        in_din      = '0;
        out_rd_en   = 1'b0;
        error_count = 0;
        void'($urandom(32'ha421_21e9));
        for (int i = 0; i < total_pixels; i++) begin
            stim[i] = pixel_t'($urandom_range(0, max_value));
        end
        for (int f = 0; f < frame_count; f++) begin
            compute_expected(f);
        end

        // Flags during reset and right after release
        repeat (reset_cycles + 2) begin
            @(negedge clock);
            if (cycle_count >= reset_cycles) begin
                reset = 1'b0;
            end
            assert (out_empty && !in_full) else begin
                error_count++;
                $display("FIFO flags wrong around reset: out_empty low or in_full high");
            end
        end

        while (rd_idx < total_pixels && cycle_count < timeout_cycles) begin
            @(negedge clock);
        end
        if (cycle_count >= timeout_cycles) begin
            error_count++;
            $display("Timeout after %0d cycles with %0d of %0d pixels read",
                     cycle_count, rd_idx, total_pixels);
        end

        // No stray pixels may follow the last frame
        repeat (40) @(negedge clock);
        assert (out_empty && rd_idx == total_pixels && expected_q.size() == 0) else begin
            error_count++;
            $display("Pixel count wrong: %0d read, %0d expected", rd_idx, total_pixels);
        end
        assert (saw_full) else begin
            error_count++;
            $display("in_full never rose while the reader was stalled");
        end

        $display("Checked %0d pixels with %0d errors", check_count, error_count);
        if (error_count == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

// File: src/edge_pkg.sv
// Pixel types, image geometry and FIFO sizing shared by the edge-thinning RTL and its testbench
package edge_pkg;

    // Frame size of one image
    localparam int image_width  = 32;
    localparam int image_height = 8;

    // Two full lines plus three pixels cover a 3x3 neighbourhood
    localparam int window_len = 2 * image_width + 3;

    // Entries held by each pixel FIFO
    localparam int fifo_depth = 16;

    // Gradient magnitude of one pixel
    typedef logic [7:0] pixel_t;

    // Sum of two 8-bit neighbours needs one extra bit
    typedef logic [8:0] grad_sum_t;

    typedef logic [$clog2(fifo_depth)-1:0]   fifo_addr_t;
    typedef logic [$clog2(image_width)-1:0]  col_t;
    typedef logic [$clog2(image_height)-1:0] row_t;

endpackage

// File: src/edge_thin_top.sv
// Edge-thinning top level with an input FIFO, the non-maximum suppressor and an output FIFO
`timescale 1ns/10ps

module edge_thin_top import edge_pkg::*; (
    input  logic   clock,
    input  logic   reset,

    // Input FIFO write side
    input  logic   in_wr_en,
    input  pixel_t in_din,
    output logic   in_full,

    // Output FIFO read side
    input  logic   out_rd_en,
    output logic   out_empty,
    output pixel_t out_dout
);

    pixel_fifo_if fifo_in ();
    pixel_fifo_if fifo_out ();

    // Raw gradient pixels from outside
    assign fifo_in.wr_en = in_wr_en;
    assign fifo_in.din   = in_din;
    assign in_full       = fifo_in.full;

    // Thinned pixels to outside
    assign fifo_out.rd_en = out_rd_en;
    assign out_empty      = fifo_out.empty;
    assign out_dout       = fifo_out.dout;

    pixel_fifo u_in_fifo (
        .clock (clock),
        .reset (reset),
        .port  (fifo_in.fifo_side)
    );

    non_maximum_suppressor u_nms (
        .clock (clock),
        .reset (reset),
        .src   (fifo_in.consumer),
        .dst   (fifo_out.producer)
    );

    pixel_fifo u_out_fifo (
        .clock (clock),
        .reset (reset),
        .port  (fifo_out.fifo_side)
    );

endmodule

// File: src/non_maximum_suppressor.sv
// 3x3 line-buffered non-maximum suppressor that reads one pixel FIFO and writes another
`timescale 1ns/10ps

module non_maximum_suppressor import edge_pkg::*; (
    input logic            clock,
    input logic            reset,
    pixel_fifo_if.consumer src,
    pixel_fifo_if.producer dst
);

    localparam int pixel_count = image_width * image_height;

    // Pixels loaded before the first centre reaches the middle tap
    localparam int fill_len = image_width + 2;

    // From this centre index on, the pixel to load lies past the frame end
    localparam int pad_start = pixel_count - fill_len;

    typedef enum logic [1:0] {
        st_prologue,
        st_suppression,
        st_output
    } state_t;

    typedef logic [$clog2(fill_len)-1:0] fill_t;

    state_t state;
    state_t next_state;

    // Index 0 holds the oldest pixel, new pixels enter at the far end
    pixel_t [0:window_len-1] window;
    pixel_t [0:window_len-1] window_c;

    fill_t  fill_count;
    fill_t  fill_count_c;
    col_t   col;
    col_t   col_c;
    row_t   row;
    row_t   row_c;
    pixel_t out_pix;
    pixel_t out_pix_c;

    // Window taps around the centre
    pixel_t pix_nw;
    pixel_t pix_n;
    pixel_t pix_ne;
    pixel_t pix_w;
    pixel_t pix_c;
    pixel_t pix_e;
    pixel_t pix_sw;
    pixel_t pix_s;
    pixel_t pix_se;

    grad_sum_t ns_sum;
    grad_sum_t ew_sum;
    grad_sum_t nw_sum;
    grad_sum_t ne_sum;

    pixel_t nms_value;
    logic   border;
    logic   in_pad;
    logic   last_pixel;
    int     center_idx;

    assign pix_nw = window[0];
    assign pix_n  = window[1];
    assign pix_ne = window[2];
    assign pix_w  = window[image_width];
    assign pix_c  = window[image_width + 1];
    assign pix_e  = window[image_width + 2];
    assign pix_sw = window[2 * image_width];
    assign pix_s  = window[2 * image_width + 1];
    assign pix_se = window[2 * image_width + 2];

    // Strength of each direction
    assign ns_sum = grad_sum_t'(pix_n) + grad_sum_t'(pix_s);
    assign ew_sum = grad_sum_t'(pix_w) + grad_sum_t'(pix_e);
    assign nw_sum = grad_sum_t'(pix_nw) + grad_sum_t'(pix_se);
    assign ne_sum = grad_sum_t'(pix_ne) + grad_sum_t'(pix_sw);

    assign border = (row == '0) || (row == row_t'(image_height - 1)) ||
                    (col == '0) || (col == col_t'(image_width - 1));

    assign last_pixel = (row == row_t'(image_height - 1)) &&
                        (col == col_t'(image_width - 1));

    assign center_idx = int'(row) * image_width + int'(col);
    assign in_pad     = (center_idx >= pad_start);

    // Earlier directions win ties
    always_comb begin
        nms_value = '0;
        if (!border) begin
            if (ns_sum >= ew_sum && ns_sum >= nw_sum && ns_sum >= ne_sum) begin
                // Compare across east-west
                if (pix_c > pix_w && pix_c >= pix_e) begin
                    nms_value = pix_c;
                end
            end else if (ew_sum >= nw_sum && ew_sum >= ne_sum) begin
                // Compare across north-south
                if (pix_c > pix_n && pix_c >= pix_s) begin
                    nms_value = pix_c;
                end
            end else if (nw_sum >= ne_sum) begin
                if (pix_c > pix_ne && pix_c >= pix_sw) begin
                    nms_value = pix_c;
                end
            end else begin
                if (pix_c > pix_nw && pix_c >= pix_se) begin
                    nms_value = pix_c;
                end
            end
        end
    end

    always_comb begin
        next_state   = state;
        window_c     = window;
        fill_count_c = fill_count;
        col_c        = col;
        row_c        = row;
        out_pix_c    = out_pix;
        src.rd_en    = 1'b0;
        dst.wr_en    = 1'b0;

        case (state)
            st_prologue: begin
                if (!src.empty) begin
                    src.rd_en = 1'b1;
                    window_c  = {window[1:window_len-1], src.dout};
                    if (fill_count == fill_t'(fill_len - 1)) begin
                        fill_count_c = '0;
                        next_state   = st_suppression;
                    end else begin
                        fill_count_c = fill_count + 1'b1;
                    end
                end
            end

            st_suppression: begin
                // Past the last input pixel zeros are shifted in without waiting
                if (in_pad) begin
                    window_c   = {window[1:window_len-1], pixel_t'(0)};
                    out_pix_c  = nms_value;
                    next_state = st_output;
                end else if (!src.empty) begin
                    src.rd_en  = 1'b1;
                    window_c   = {window[1:window_len-1], src.dout};
                    out_pix_c  = nms_value;
                    next_state = st_output;
                end
            end

            st_output: begin
                // Window is held here until the output FIFO has room
                if (!dst.full) begin
                    dst.wr_en  = 1'b1;
                    next_state = st_suppression;
                    if (last_pixel) begin
                        col_c      = '0;
                        row_c      = '0;
                        next_state = st_prologue;
                    end else if (col == col_t'(image_width - 1)) begin
                        col_c = '0;
                        row_c = row + 1'b1;
                    end else begin
                        col_c = col + 1'b1;
                    end
                end
            end

            default: begin
                next_state = st_prologue;
            end
        endcase
    end

    assign dst.din = out_pix;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state      <= st_prologue;
            window     <= '0;
            fill_count <= '0;
            col        <= '0;
            row        <= '0;
        end else begin
            state      <= next_state;
            window     <= window_c;
            fill_count <= fill_count_c;
            col        <= col_c;
            row        <= row_c;
        end
    end

    always_ff @(posedge clock) begin
        out_pix <= out_pix_c;
    end

endmodule

// File: src/pixel_fifo.sv
// Show-ahead synchronous pixel FIFO with full and empty flags, one instance per FIFO link
`timescale 1ns/10ps

module pixel_fifo import edge_pkg::*; (
    input logic             clock,
    input logic             reset,
    pixel_fifo_if.fifo_side port
);

    // One extra bit so a full buffer can be told apart from an empty one
    typedef logic [$clog2(fifo_depth):0] count_t;

    pixel_t     mem [fifo_depth];
    fifo_addr_t wr_ptr;
    fifo_addr_t rd_ptr;
    count_t     count;
    logic       do_write;
    logic       do_read;

    // Wraps at the last entry, so the depth need not be a power of two
    function automatic fifo_addr_t next_ptr(input fifo_addr_t ptr);
        if (ptr == fifo_addr_t'(fifo_depth - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    // Writes while full and reads while empty are dropped
    assign do_write = port.wr_en && !port.full;
    assign do_read  = port.rd_en && !port.empty;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_write) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (do_read) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({do_write, do_read})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Storage array
    always_ff @(posedge clock) begin
        if (do_write) begin
            mem[wr_ptr] <= port.din;
        end
    end

    assign port.full  = (count == count_t'(fifo_depth));
    assign port.empty = (count == '0);

    // Head word is visible without a read
    assign port.dout = mem[rd_ptr];

endmodule

// File: src/pixel_fifo_if.sv
// Write and read sides of one pixel FIFO, connected between a producer, the FIFO and a consumer
`timescale 1ns/10ps

interface pixel_fifo_if import edge_pkg::*; ();

    // Write side
    logic   wr_en;
    pixel_t din;
    logic   full;

    // Read side, show-ahead so dout is valid while empty is low
    logic   rd_en;
    logic   empty;
    pixel_t dout;

    modport fifo_side (
        input  wr_en,
        input  din,
        output full,
        input  rd_en,
        output empty,
        output dout
    );

    modport producer (output wr_en, output din, input full);

    modport consumer (output rd_en, input empty, input dout);

endinterface
